// File: flist.f
+incdir+src
src/int_unit_pkg.sv
src/int_alu.sv
src/int_multiplier.sv
src/int_divider.sv
src/integer_unit.sv
verif/integer_unit_assert.sv
verif/integer_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the integer unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module integer_unit_tb -o integer_unit_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/integer_unit_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0

// File: verif/integer_unit_tb.sv
`timescale 1ns/1ps
`include "int_unit_cfg.svh"

module integer_unit_tb import int_unit_pkg::*; ();

    localparam int N_OPS     = 80;
    localparam int LIMIT     = N_OPS * `DIV_CYCLES + 500;
    localparam int HOLD      = 5;
    localparam itu_valid_t U_ALU = itu_valid_t'(3'b100);
    localparam itu_valid_t U_MUL = itu_valid_t'(3'b010);
    localparam itu_valid_t U_DIV = itu_valid_t'(3'b001);

    // One outstanding result, value holds taken above the data word
    typedef struct packed {
        logic [31:0]            due;
        logic [`DATA_WIDTH:0]   value;
        instr_packet_t          packet;
    } expect_t;

    logic          clk_i;
    logic          reset_i;
    logic          flush_i;
    logic          mul_en_i;
    logic          div_en_i;
    logic          save_next_pc_i;
    instr_packet_t ipacket_i;
    itu_uop_t      operation_i;
    itu_valid_t    data_valid_i;
    data_word_t    operand_1_i;
    data_word_t    operand_2_i;
    logic          taken_o;
    data_word_t    result_o;
    instr_packet_t ipacket_o;
    logic          data_valid_o;
    logic          div_busy_o;

    integer  seed = 32'h6bd2_8bf3;
    int      cycle = 0;
    int      error_count = 0;
    int      tag_count = 0;
    expect_t exp_q[$];

    integer_unit u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Cycle counter, also the run limit
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            error_count++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Testbench failed");
            $fatal(1, "Mismatch");
        end
    endtask

    // ====================
    // Reference model
    // ====================

    // Result rules of the RISC-V integer and M extension operations
    function automatic logic [`DATA_WIDTH:0] expected_result(input itu_valid_t unit,
            input itu_uop_t uop, input data_word_t a, input data_word_t b);
        logic signed [65:0] pa;
        logic signed [65:0] pb;
        logic signed [65:0] pp;
        logic               sgn;
        data_word_t         q;
        data_word_t         r;
        logic [`DATA_WIDTH:0] res;
        res = '0;
        if (unit.alu) begin
            case (uop.alu_op)
                ADD:  res[31:0] = a + b;
                SUB:  res[31:0] = a - b;
                SLT:  res[0] = $signed(a) < $signed(b);
                SLTU: res[0] = a < b;
                AND:  res[31:0] = a & b;
                OR:   res[31:0] = a | b;
                XOR:  res[31:0] = a ^ b;
                SLL:  res[31:0] = a << b[4:0];
                SRL:  res[31:0] = a >> b[4:0];
                SRA:  res[31:0] = $signed(a) >>> b[4:0];
                BEQ:  res[32] = (a == b);
                BNE:  res[32] = (a != b);
                BLT:  res[32] = $signed(a) < $signed(b);
                BGE:  res[32] = $signed(a) >= $signed(b);
                BLTU: res[32] = a < b;
                default: res[32] = a >= b;
            endcase
        end else if (unit.mul) begin
            pa = (uop.mul_op == MULH || uop.mul_op == MULHSU) ? {{34{a[31]}}, a} : {34'b0, a};
            pb = (uop.mul_op == MULH) ? {{34{b[31]}}, b} : {34'b0, b};
            pp = pa * pb;
            res[31:0] = (uop.mul_op == MUL) ? pp[31:0] : pp[63:32];
        end else begin
            sgn = (uop.div_op == DIV) || (uop.div_op == REM);
            if (b == '0) begin
                q = '1;
                r = a;
            end else if (sgn && a == 32'h8000_0000 && b == '1) begin
                q = a;
                r = '0;
            end else if (sgn) begin
                q = $signed(a) / $signed(b);
                r = $signed(a) % $signed(b);
            end else begin
                q = a / b;
                r = a % b;
            end
            res[31:0] = (uop.div_op == REM || uop.div_op == REMU) ? r : q;
        end
        return res;
    endfunction

    // Compare at the falling edge, where the outputs have settled
    always @(negedge clk_i) begin
        int idx;
        idx = -1;
        if (!reset_i) begin
            foreach (exp_q[i]) begin
                if (exp_q[i].due == cycle) idx = i;
            end
            if (idx >= 0) begin
                check("data_valid_o", 64'(data_valid_o), 64'd1);
                check("result_o", 64'(result_o), 64'(exp_q[idx].value[31:0]));
                check("ipacket_o", 64'(ipacket_o), 64'(exp_q[idx].packet));
                check("taken_o", 64'(taken_o), 64'(exp_q[idx].value[32]));
                exp_q.delete(idx);
            end else begin
                check("data_valid_o", 64'(data_valid_o), 64'd0);
                check("taken_o", 64'(taken_o), 64'd0);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    // Edge values turn up about a third of the time
    function automatic data_word_t pick_operand();
        logic [2:0] sel;
        sel = 3'($random(seed));
        case (sel)
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            default: return data_word_t'($random(seed));
        endcase
    endfunction

    function automatic itu_uop_t make_uop(input alu_op_e a, input mul_op_e m, input div_op_e d);
        itu_uop_t u;
        u.alu_op = a;
        u.mul_op = m;
        u.div_op = d;
        return u;
    endfunction

    task automatic issue_op(input itu_valid_t unit, input itu_uop_t uop, input data_word_t a,
            input data_word_t b, input logic link, input int hold);
        instr_packet_t pkt;
        expect_t       e;
        int            latency;
        tag_count++;
        pkt.instr_addr = data_word_t'($random(seed)) & ~32'h3;
        pkt.rob_tag    = 6'(tag_count % 63 + 1);
        pkt.dest_reg   = 5'($random(seed));
        latency = unit.alu ? 0 : (unit.mul ? `MUL_STAGES : `DIV_CYCLES);
        @(posedge clk_i);
        ipacket_i      <= pkt;
        operation_i    <= uop;
        data_valid_i   <= unit;
        operand_1_i    <= a;
        operand_2_i    <= b;
        save_next_pc_i <= link;
        flush_i        <= 1'b0;
        e.due    = 32'(cycle + 1 + latency + hold);
        e.value  = expected_result(unit, uop, link ? pkt.instr_addr : a, b);
        e.packet = pkt;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            data_valid_i   <= '0;
            save_next_pc_i <= 1'b0;
            flush_i        <= 1'b0;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) idle_cycles(1);
        idle_cycles(1);
    endtask

    // Busy must cover every cycle up to the result cycle
    task automatic run_div(input div_op_e op, input data_word_t a, input data_word_t b);
        issue_op(U_DIV, make_uop(ADD, MUL, op), a, b, 1'b0, 0);
        idle_cycles(1);
        repeat (`DIV_CYCLES - 1) begin
            @(negedge clk_i);
            check("div_busy_o", 64'(div_busy_o), 64'd1);
        end
        @(negedge clk_i);
        check("div_busy_o", 64'(div_busy_o), 64'd0);
        drain();
    endtask

    initial begin
        data_word_t pair_a[4];
        data_word_t pair_b[4];
        int         flush_cyc;
        pair_a = '{32'd7, 32'd3, 32'd12, 32'hFFFF_FFFF};
        pair_b = '{32'd7, 32'd12, 32'd3, 32'd1};
        reset_i = 1'b1;
        flush_i = 1'b0;
        mul_en_i = 1'b1;
        div_en_i = 1'b1;
        save_next_pc_i = 1'b0;
        ipacket_i = '0;
        operation_i = '0;
        data_valid_i = '0;
        operand_1_i = '0;
        operand_2_i = '0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        // Random ALU work back to back, then a link address
        for (int k = 0; k < 20; k++)
            issue_op(U_ALU, make_uop(alu_op_e'(4'(k % 10)), MUL, DIV),
                     pick_operand(), pick_operand(), 1'b0, 0);
        issue_op(U_ALU, make_uop(ADD, MUL, DIV), pick_operand(), 32'd4, 1'b1, 0);
        drain();

        // Branches on equal, less and greater pairs, the last pair differs in sign only
        for (int k = 10; k < 16; k++)
            for (int p = 0; p < 4; p++)
                issue_op(U_ALU, make_uop(alu_op_e'(4'(k)), MUL, DIV),
                         pair_a[p], pair_b[p], 1'b0, 0);
        drain();

        // Multiply bursts
        for (int k = 0; k < 4; k++)
            issue_op(U_MUL, make_uop(ADD, mul_op_e'(2'(k)), DIV),
                     pick_operand(), pick_operand(), 1'b0, 0);
        drain();
        for (int k = 0; k < `MUL_STAGES; k++)
            issue_op(U_MUL, make_uop(ADD, mul_op_e'(2'(3 - k)), DIV),
                     pick_operand(), pick_operand(), 1'b0, 0);
        drain();

        // Divisions, then zero divisors and signed overflow
        for (int k = 0; k < 12; k++)
            run_div(div_op_e'(2'(k % 4)), pick_operand(), pick_operand());
        for (int k = 0; k < 4; k++)
            run_div(div_op_e'(2'(k)), pick_operand(), '0);
        run_div(DIV, 32'h8000_0000, '1);
        run_div(REM, 32'h8000_0000, '1);

        // Flush with a division and two multiplies in flight
        issue_op(U_DIV, make_uop(ADD, MUL, DIVU), pick_operand(), pick_operand(), 1'b0, 0);
        issue_op(U_MUL, make_uop(ADD, MULHU, DIV), pick_operand(), pick_operand(), 1'b0, 0);
        issue_op(U_MUL, make_uop(ADD, MUL, DIV), pick_operand(), pick_operand(), 1'b0, 0);
        @(posedge clk_i);
        data_valid_i <= '0;
        flush_i <= 1'b1;
        flush_cyc = cycle + 1;
        for (int i = exp_q.size() - 1; i >= 0; i--)
            if (exp_q[i].due > 32'(flush_cyc)) exp_q.delete(i);
        idle_cycles(1);
        // The cleared division leaves the divider free right after the flush
        @(negedge clk_i);
        check("div_busy_o", 64'(div_busy_o), 64'd0);
        issue_op(U_ALU, make_uop(XOR, MUL, DIV), pick_operand(), pick_operand(), 1'b0, 0);
        issue_op(U_MUL, make_uop(ADD, MULH, DIV), pick_operand(), pick_operand(), 1'b0, 0);
        drain();

        // Multiplier held for a known number of cycles
        for (int k = 0; k < `MUL_STAGES; k++)
            issue_op(U_MUL, make_uop(ADD, mul_op_e'(2'(k)), DIV),
                     pick_operand(), pick_operand(), 1'b0, HOLD);
        repeat (HOLD) begin
            @(posedge clk_i);
            data_valid_i <= '0;
            mul_en_i <= 1'b0;
        end
        @(posedge clk_i);
        mul_en_i <= 1'b1;
        drain();

        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : integer_unit_tb

// File: verif/integer_unit_assert.sv
`timescale 1ns/1ps

module integer_unit_assert import int_unit_pkg::*; (
    input logic          clk_i,
    input logic          reset_i,
    input logic          flush_i,
    input itu_valid_t    issue_valid_i,
    input logic          alu_valid_i,
    input logic          mul_valid_i,
    input logic          div_valid_i,
    input logic          div_busy_i,
    input data_word_t    result_i,
    input instr_packet_t ipacket_i,
    input logic          data_valid_i
);

    // The output merge is a plain OR, so unit results must never overlap
    unit_valid_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({alu_valid_i, mul_valid_i, div_valid_i}))
        else $error("More than one unit result valid in the same cycle");

    // Idle outputs stay at zero
    idle_output_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        !data_valid_i |-> (result_i == '0) && (ipacket_i == '0))
        else $error("Result or packet nonzero while output valid is low");

    no_div_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_valid_i.div |-> !div_busy_i)
        else $error("Division issued while the divider is busy");

    // Only a fresh ALU operation may complete right after a flush
    flush_kills_work: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |=> (!data_valid_i || issue_valid_i.alu))
        else $error("Result from flushed work appeared after a flush");

endmodule : integer_unit_assert

bind integer_unit integer_unit_assert u_assert (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .issue_valid_i (data_valid_i),
    .alu_valid_i   (alu_valid),
    .mul_valid_i   (mul_valid),
    .div_valid_i   (div_valid),
    .div_busy_i    (div_busy_o),
    .result_i      (result_o),
    .ipacket_i     (ipacket_o),
    .data_valid_i  (data_valid_o)
);

// File: src/integer_unit.sv
`timescale 1ns/1ps
`include "int_unit_cfg.svh"

module integer_unit import int_unit_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          mul_en_i,
    input  logic          div_en_i,
    input  logic          save_next_pc_i,
    input  instr_packet_t ipacket_i,
    input  itu_uop_t      operation_i,
    input  itu_valid_t    data_valid_i,
    input  data_word_t    operand_1_i,
    input  data_word_t    operand_2_i,
    output logic          taken_o,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          data_valid_o,
    output logic          div_busy_o
);

    // ====================
    // ALU
    // ====================

    data_word_t    alu_operand_a;
    data_word_t    alu_result;
    data_word_t    alu_result_g;
    logic          alu_valid;
    instr_packet_t alu_packet;

    // Link values are formed as instruction address plus operand 2
    assign alu_operand_a = save_next_pc_i ? ipacket_i.instr_addr : operand_1_i;

    // A flush kills the ALU operation of the same cycle, taken included
    int_alu u_alu (
        .operand_a_i (alu_operand_a),
        .operand_b_i (operand_2_i),
        .operation_i (operation_i.alu_op),
        .valid_i     (data_valid_i.alu && !flush_i),
        .taken_o     (taken_o),
        .result_o    (alu_result),
        .valid_o     (alu_valid)
    );

    assign alu_result_g = alu_valid ? alu_result : '0;
    assign alu_packet   = alu_valid ? ipacket_i : NO_OPERATION;

    // ====================
    // Multiplier
    // ====================

    data_word_t                       mul_result;
    data_word_t                       mul_result_g;
    logic                             mul_valid;
    instr_packet_t [`MUL_STAGES-1:0]  mul_packet_q;
    instr_packet_t                    mul_packet;

    int_multiplier u_mul (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .enable_i       (mul_en_i),
        .clear_i        (flush_i),
        .multiplicand_i (operand_1_i),
        .multiplier_i   (operand_2_i),
        .operation_i    (operation_i.mul_op),
        .valid_i        (data_valid_i.mul),
        .product_o      (mul_result),
        .valid_o        (mul_valid)
    );

    // Packets shift in step with the multiplier pipeline and hold with it
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            mul_packet_q <= '0;
        end else if (mul_en_i) begin
            mul_packet_q[0] <= ipacket_i;
            for (int i = 1; i < `MUL_STAGES; i++) begin
                mul_packet_q[i] <= mul_packet_q[i-1];
            end
        end
    end

    assign mul_result_g = mul_valid ? mul_result : '0;
    assign mul_packet   = mul_valid ? mul_packet_q[`MUL_STAGES-1] : NO_OPERATION;

    // ====================
    // Divider and merge
    // ====================

    data_word_t    div_result;
    data_word_t    div_result_g;
    logic          div_valid;
    instr_packet_t div_packet_q;
    instr_packet_t div_packet;

    int_divider u_div (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (div_en_i),
        .clear_i     (flush_i),
        .dividend_i  (operand_1_i),
        .divisor_i   (operand_2_i),
        .operation_i (operation_i.div_op),
        .valid_i     (data_valid_i.div),
        .quotient_o  (div_result),
        .valid_o     (div_valid),
        .busy_o      (div_busy_o)
    );

    // Capture exactly when the divider accepts, it holds one operation at a time
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            div_packet_q <= NO_OPERATION;
        end else if (data_valid_i.div && div_en_i && !div_busy_o) begin
            div_packet_q <= ipacket_i;
        end
    end

    assign div_result_g = div_valid ? div_result : '0;
    assign div_packet   = div_valid ? div_packet_q : NO_OPERATION;

    // The issuer keeps completions apart, so the gated paths can simply be ORed
    assign result_o     = alu_result_g | mul_result_g | div_result_g;
    assign ipacket_o    = instr_packet_t'(alu_packet | mul_packet | div_packet);
    assign data_valid_o = alu_valid | mul_valid | div_valid;

endmodule : integer_unit

// File: src/int_divider.sv
`timescale 1ns/1ps
`include "int_unit_cfg.svh"

module int_divider import int_unit_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       clear_i,
    input  data_word_t dividend_i,
    input  data_word_t divisor_i,
    input  div_op_e    operation_i,
    input  logic       valid_i,
    output data_word_t quotient_o,
    output logic       valid_o,
    output logic       busy_o
);

    localparam int W     = `DATA_WIDTH;
    localparam int CNT_W = $clog2(`DATA_WIDTH);

    typedef enum logic [1:0] {IDLE, PREPARE, ITERATE, FINISH} div_state_e;

    div_state_e       state_q;
    logic [CNT_W-1:0] step_q;
    div_op_e          op_q;
    data_word_t       quo_q;
    data_word_t       rem_q;
    data_word_t       dsr_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             zero_q;
    logic             accept;
    logic             is_signed;
    logic [W:0]       partial;
    logic [W:0]       trial;
    data_word_t       quo_fix;
    data_word_t       rem_fix;

    // A new division is taken when idle or in the result cycle of the previous one
    assign accept    = valid_i && enable_i && ((state_q == IDLE) || (state_q == FINISH));
    assign is_signed = (op_q == DIV) || (op_q == REM);

    // Restoring step, shift in the next dividend bit and try to subtract
    assign partial = {rem_q, quo_q[W-1]};
    assign trial   = partial - {1'b0, dsr_q};

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else if (enable_i) begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= PREPARE;
                    end
                end
                PREPARE: begin
                    state_q <= ITERATE;
                    step_q  <= '0;
                end
                ITERATE: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(W - 1)) begin
                        state_q <= FINISH;
                    end
                end
                FINISH:  state_q <= accept ? PREPARE : IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // ====================
    // Datapath
    // ====================

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q  <= operation_i;
            quo_q <= dividend_i;
            dsr_q <= divisor_i;
        end else if (enable_i && (state_q == PREPARE)) begin
            // Record result signs, then work on magnitudes only
            neg_quo_q <= is_signed && (quo_q[W-1] ^ dsr_q[W-1]);
            neg_rem_q <= is_signed && quo_q[W-1];
            zero_q    <= (dsr_q == '0);
            quo_q     <= (is_signed && quo_q[W-1]) ? -quo_q : quo_q;
            dsr_q     <= (is_signed && dsr_q[W-1]) ? -dsr_q : dsr_q;
            rem_q     <= '0;
        end else if (enable_i && (state_q == ITERATE)) begin
            // The quotient bit enters where the dividend bit left
            if (!trial[W]) begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= partial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // A zero divisor forces all ones, the remainder already equals the dividend
    // Signed overflow needs no special path, the magnitude 2^(W-1) negates to itself
    assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign quotient_o = ((op_q == REM) || (op_q == REMU)) ? rem_fix : quo_fix;
    assign valid_o    = (state_q == FINISH) && enable_i;

    // Busy drops in the result cycle unless the divider is held there
    assign busy_o = (state_q == PREPARE) || (state_q == ITERATE) ||
                    ((state_q == FINISH) && !enable_i);

endmodule : int_divider

// File: src/int_multiplier.sv
`timescale 1ns/1ps
`include "int_unit_cfg.svh"

module int_multiplier import int_unit_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       clear_i,
    input  data_word_t multiplicand_i,
    input  data_word_t multiplier_i,
    input  mul_op_e    operation_i,
    input  logic       valid_i,
    output data_word_t product_o,
    output logic       valid_o
);

    localparam int W = `DATA_WIDTH;
    localparam int S = `MUL_STAGES;

    logic                      sign_a;
    logic                      sign_b;
    logic signed [W:0]         mcand_ext;
    logic signed [W:0]         mplier_ext;
    logic signed [2*W+1:0]     full_product;
    logic [S-1:0][2*W-1:0]     product_q;
    logic [S-1:0]              high_q;
    logic [S-1:0]              valid_q;

    // MULH treats both operands as signed, MULHSU only the first one
    assign sign_a = (operation_i == MULH) || (operation_i == MULHSU);
    assign sign_b = (operation_i == MULH);

    // One extra bit lets a single signed multiplier cover all three signedness cases
    assign mcand_ext  = {sign_a && multiplicand_i[W-1], multiplicand_i};
    assign mplier_ext = {sign_b && multiplier_i[W-1], multiplier_i};

    assign full_product = mcand_ext * mplier_ext;

    // Valid bits are the only control state in the pipeline
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            valid_q <= '0;
        end else if (enable_i) begin
            valid_q <= {valid_q[S-2:0], valid_i};
        end
    end

    // Product and word select move along with the valid bits
    always_ff @(posedge clk_i) begin
        if (enable_i) begin
            product_q[0] <= full_product[2*W-1:0];
            high_q[0]    <= (operation_i != MUL);
            for (int i = 1; i < S; i++) begin
                product_q[i] <= product_q[i-1];
                high_q[i]    <= high_q[i-1];
            end
        end
    end

    // A held pipeline must not repeat its last result
    assign valid_o   = valid_q[S-1] && enable_i;
    assign product_o = high_q[S-1] ? product_q[S-1][2*W-1:W] : product_q[S-1][W-1:0];

endmodule : int_multiplier

// File: src/int_alu.sv
`timescale 1ns/1ps
`include "int_unit_cfg.svh"

module int_alu import int_unit_pkg::*; (
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,
    input  alu_op_e    operation_i,
    input  logic       valid_i,
    output logic       taken_o,
    output data_word_t result_o,
    output logic       valid_o
);

    localparam int SHAMT_W = $clog2(`DATA_WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               equal;
    logic               signed_lt;
    logic               unsigned_lt;
    logic               branch_cond;

    // Shifts only look at the low bits of operand B
    assign shamt = operand_b_i[SHAMT_W-1:0];

    // Shared comparators feed both SLT/SLTU and the branch conditions
    assign equal       = (operand_a_i == operand_b_i);
    assign signed_lt   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign unsigned_lt = (operand_a_i < operand_b_i);

    always_comb begin
        result_o    = '0;
        branch_cond = 1'b0;

        case (operation_i)
            ADD:  result_o = operand_a_i + operand_b_i;
            SUB:  result_o = operand_a_i - operand_b_i;
            SLT:  result_o = data_word_t'(signed_lt);
            SLTU: result_o = data_word_t'(unsigned_lt);
            AND:  result_o = operand_a_i & operand_b_i;
            OR:   result_o = operand_a_i | operand_b_i;
            XOR:  result_o = operand_a_i ^ operand_b_i;
            SLL:  result_o = operand_a_i << shamt;
            SRL:  result_o = operand_a_i >> shamt;
            SRA:  result_o = data_word_t'($signed(operand_a_i) >>> shamt);

            // Branches leave the result at zero and only produce the condition
            BEQ:  branch_cond = equal;
            BNE:  branch_cond = !equal;
            BLT:  branch_cond = signed_lt;
            BGE:  branch_cond = !signed_lt;
            BLTU: branch_cond = unsigned_lt;
            BGEU: branch_cond = !unsigned_lt;

            default: begin
                result_o    = '0;
                branch_cond = 1'b0;
            end
        endcase
    end

    // Taken is only meaningful for a valid branch
    assign taken_o = valid_i && branch_cond;

    // Fully combinational, the result is ready in the issue cycle
    assign valid_o = valid_i;

endmodule : int_alu

// File: src/int_unit_pkg.sv
`include "int_unit_cfg.svh"

package int_unit_pkg;

    // One operand or result word
    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    // Instruction information that travels alongside the operands
    typedef struct packed {
        data_word_t instr_addr;
        logic [5:0] rob_tag;
        logic [4:0] dest_reg;
    } instr_packet_t;

    // An all zero packet marks an empty slot
    localparam instr_packet_t NO_OPERATION = '0;

    // ====================
    // Opcodes
    // ====================

    // ALU operations, the last six resolve branches
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_op_e;

    // MUL returns the low word, the others the high word
    typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mul_op_e;

    // DIV and DIVU return the quotient, REM and REMU the remainder
    typedef enum logic [1:0] {DIV, DIVU, REM, REMU} div_op_e;

    // Operation bundle, each unit reads only its own field
    typedef struct packed {
        alu_op_e alu_op;
        mul_op_e mul_op;
        div_op_e div_op;
    } itu_uop_t;

    // Selects which unit takes the operands this cycle
    typedef struct packed {
        logic alu;
        logic mul;
        logic div;
    } itu_valid_t;

endpackage : int_unit_pkg

// File: src/int_unit_cfg.svh
`ifndef INT_UNIT_CFG_SVH
`define INT_UNIT_CFG_SVH

// Width of every operand, result and instruction address
`define DATA_WIDTH 32

// Register stages between the multiplier inputs and its result
`define MUL_STAGES 3

// Cycles from a division valid to its result
// One cycle to load, one to prepare, one restoring step per bit and the result cycle
// overlap so that the total is the data width plus two
`define DIV_CYCLES (`DATA_WIDTH + 2)

`endif
